// ==== sources.f ====
fetch_pkg.sv
fetch_pc_unit.sv
icache_interface.sv
icache_line_mem.sv
fetch_instr_queue.sv
fetch_top.sv
tb_clock_gen.sv
fetch_top_properties.sv
tb_fetch_top.sv

// ==== Makefile ====
SIM := obj_dir/Vtb_fetch_top
SRCS := $(shell cat sources.f)

.PHONY: all run clean

all: run

$(SIM): sources.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module tb_fetch_top -f sources.f

run: $(SIM)
	@out=$$(./$(SIM)); \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf obj_dir

// ==== tb_fetch_top.sv ====
/* Testbench top for the fetch front end with random line data,
   stream model, value checks, watchdog and summary */
`timescale 1ns/1ps

module tb_fetch_top
    import fetch_pkg::*;
();

    localparam int          CLK_PERIOD   = 40;
    localparam int          RESET_CYCLES = 5;
    localparam addr_t       RESET_PC     = 12'h100;
    localparam int unsigned MEM_LATENCY  = 3;
    localparam int unsigned QUEUE_DEPTH  = 4;
    localparam int unsigned SEED         = 53645;

    // Instruction counts of the five tests
    localparam int RESET_RUN_LEN     = 16;
    localparam int LINE_RUN_LEN      = 64;
    localparam int NUM_REDIRECTS     = 12;
    localparam int REDIRECT_RUN_LEN  = 4;
    localparam int BACKPRESS_RUN_LEN = 200;
    localparam int NUM_REWRITES      = 2;
    localparam int TOTAL_INSTRS = RESET_RUN_LEN + LINE_RUN_LEN
        + NUM_REDIRECTS * REDIRECT_RUN_LEN + BACKPRESS_RUN_LEN
        + NUM_REWRITES * WORDS_PER_LINE;
    localparam longint WATCHDOG_NS =
        longint'(TOTAL_INSTRS) * longint'(MEM_LATENCY + 8) * longint'(CLK_PERIOD);

    logic      clk;
    logic      rstn;
    logic      redirect_valid;
    addr_t     redirect_pc;
    logic      mem_wr_en;
    line_idx_t mem_wr_idx;
    line_t     mem_wr_line;
    logic      instr_valid;
    instr_t    instr;
    addr_t     instr_pc;
    logic      instr_ready;

    // Model copy of the line store and the next expected fetch address
    line_t model_mem [NUM_LINES];
    addr_t exp_pc;

    int error_cnt;
    int check_cnt;
    int accept_cnt;

    tb_clock_gen #(
        .PERIOD_NS    (CLK_PERIOD),
        .RESET_CYCLES (RESET_CYCLES)
    ) u_clk_gen (
        .clk_o  (clk),
        .rstn_o (rstn)
    );

    fetch_top #(
        .RESET_PC    (RESET_PC),
        .MEM_LATENCY (MEM_LATENCY),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) uut (
        .clk_i            (clk),
        .rstn_i           (rstn),
        .redirect_valid_i (redirect_valid),
        .redirect_pc_i    (redirect_pc),
        .mem_wr_en_i      (mem_wr_en),
        .mem_wr_idx_i     (mem_wr_idx),
        .mem_wr_line_i    (mem_wr_line),
        .instr_valid_o    (instr_valid),
        .instr_o          (instr),
        .instr_pc_o       (instr_pc),
        .instr_ready_i    (instr_ready)
    );

    bind fetch_top fetch_top_properties u_props (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .redirect_valid_i (redirect_valid_i),
        .instr_valid_i    (instr_valid_o),
        .instr_i          (instr_o),
        .instr_pc_i       (instr_pc_o),
        .instr_ready_i    (instr_ready_i),
        .mem_req_valid_i  (mem_req_valid),
        .mem_req_ready_i  (mem_req_ready),
        .mem_resp_valid_i (mem_resp_valid)
    );

    task automatic check_value(input string name, input line_t expected, input line_t actual);
        check_cnt++;
        if (actual !== expected) begin
            error_cnt++;
            $display("ERROR at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
        end
    endtask

    // Word 0 of a line sits in the low bits, PC bits 3:2 pick the word
    function automatic instr_t expected_word(input addr_t pc);
        line_t data;
        data = model_mem[pc[ADDR_WIDTH-1:LINE_OFFSET]];
        return data[int'(pc[LINE_OFFSET-1:2]) * INSTR_WIDTH +: INSTR_WIDTH];
    endfunction

    function automatic line_t random_line();
        return {$urandom(), $urandom(), $urandom(), $urandom()};
    endfunction

    // One line through the load port, decode held off meanwhile
    task automatic write_line(input line_idx_t idx, input line_t data);
        @(negedge clk);
        instr_ready = 1'b0;
        redirect_valid = 1'b0;
        mem_wr_en = 1'b1;
        mem_wr_idx = idx;
        mem_wr_line = data;
        model_mem[idx] = data;
        if (!rstn) begin
            check_value("instr_valid_o", '0, line_t'(instr_valid));
        end
    endtask

    // Drive one cycle and score the handshake that completes at the next rising edge
    task automatic drive_cycle(input logic ready, input logic redir, input addr_t target);
        @(negedge clk);
        mem_wr_en = 1'b0;
        redirect_valid = redir;
        redirect_pc = target;
        // No decode handshake in a redirect cycle
        instr_ready = ready && !redir;
        if (instr_valid && instr_ready) begin
            check_value("instr_pc_o", line_t'(exp_pc), line_t'(instr_pc));
            check_value("instr_o", line_t'(expected_word(exp_pc)), line_t'(instr));
            exp_pc = exp_pc + addr_t'(4);
            accept_cnt++;
        end
        if (redir) begin
            exp_pc = target;
        end
    endtask

    task automatic run_instrs(input int n, input bit random_ready);
        int goal;
        goal = accept_cnt + n;
        while (accept_cnt < goal) begin
            if (random_ready) begin
                drive_cycle($urandom_range(1, 0) == 1, 1'b0, '0);
            end else begin
                drive_cycle(1'b1, 1'b0, '0);
            end
        end
    endtask

    task automatic report_test(input int num, input string name, input int errs_before,
                               input int instrs_before);
        $display("Test %0d %s finished: %0d instructions, %0d errors", num, name,
                 accept_cnt - instrs_before, error_cnt - errs_before);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        int        errs_before;
        int        instrs_before;
        int        gap;
        line_idx_t base_idx;
        line_idx_t rw_idx;
        addr_t     target;

        void'($urandom(SEED));
        redirect_valid = 1'b0;
        redirect_pc = '0;
        mem_wr_en = 1'b0;
        mem_wr_idx = '0;
        mem_wr_line = '0;
        instr_ready = 1'b0;
        exp_pc = RESET_PC;
        error_cnt = 0;
        check_cnt = 0;
        accept_cnt = 0;

        // Test 1, loading starts in reset at the reset line and stays ahead of fetch
        errs_before = error_cnt;
        instrs_before = accept_cnt;
        base_idx = RESET_PC[ADDR_WIDTH-1:LINE_OFFSET];
        for (int i = 0; i < NUM_LINES; i++) begin
            write_line(base_idx + line_idx_t'(i), random_line());
        end
        run_instrs(RESET_RUN_LEN, 1'b0);
        report_test(1, "reset and first fetch", errs_before, instrs_before);

        // Test 2, sequential run over several lines
        errs_before = error_cnt;
        instrs_before = accept_cnt;
        run_instrs(LINE_RUN_LEN, 1'b0);
        report_test(2, "line crossing run", errs_before, instrs_before);

        // Test 3, redirects at random moments to aligned random targets
        errs_before = error_cnt;
        instrs_before = accept_cnt;
        for (int r = 0; r < NUM_REDIRECTS; r++) begin
            gap = $urandom_range(3, 0);
            for (int g = 0; g < gap; g++) begin
                drive_cycle(1'b1, 1'b0, '0);
            end
            target = addr_t'($urandom());
            target[1:0] = 2'b00;
            drive_cycle(1'b0, 1'b1, target);
            run_instrs(REDIRECT_RUN_LEN, 1'b0);
        end
        report_test(3, "random redirects", errs_before, instrs_before);

        // Test 4, decode stalls about half the cycles
        errs_before = error_cnt;
        instrs_before = accept_cnt;
        run_instrs(BACKPRESS_RUN_LEN, 1'b1);
        report_test(4, "decode back-pressure", errs_before, instrs_before);

        // Test 5, new line contents then a jump to the start of that line
        errs_before = error_cnt;
        instrs_before = accept_cnt;
        for (int w = 0; w < NUM_REWRITES; w++) begin
            rw_idx = line_idx_t'($urandom());
            write_line(rw_idx, random_line());
            target = {rw_idx, 4'h0};
            drive_cycle(1'b0, 1'b1, target);
            run_instrs(WORDS_PER_LINE, 1'b0);
        end
        report_test(5, "line rewrite", errs_before, instrs_before);

        $display("Summary: %0d checks, %0d instructions, %0d errors",
                 check_cnt, accept_cnt, error_cnt);
        if (error_cnt == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== fetch_top_properties.sv ====
/* Concurrent checks on the decode handshake, reset behavior
   and line store requests */
`timescale 1ns/1ps

module fetch_top_properties
    import fetch_pkg::*;
(
    input logic   clk_i,
    input logic   rstn_i,
    input logic   redirect_valid_i,
    input logic   instr_valid_i,
    input instr_t instr_i,
    input addr_t  instr_pc_i,
    input logic   instr_ready_i,
    input logic   mem_req_valid_i,
    input logic   mem_req_ready_i,
    input logic   mem_resp_valid_i
);

    // A read is outstanding from its acceptance up to its response cycle
    logic busy_q;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            busy_q <= 1'b0;
        end else if (mem_req_valid_i && mem_req_ready_i) begin
            busy_q <= 1'b1;
        end else if (mem_resp_valid_i) begin
            busy_q <= 1'b0;
        end
    end

    // Nothing offered to decode while reset is held
    reset_quiet: assert property (@(posedge clk_i) !rstn_i |-> !instr_valid_i)
        else $error("instr_valid_o high during reset");

    // Stalled head entry holds until taken or flushed
    stall_stable: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (instr_valid_i && !instr_ready_i && !redirect_valid_i)
        |=> (instr_valid_i && $stable(instr_i) && $stable(instr_pc_i)))
        else $error("decode output changed while stalled");

    // One outstanding read, so no new request before the last response
    req_when_idle: assert property (@(posedge clk_i) disable iff (!rstn_i)
        mem_req_valid_i |-> (!busy_q || mem_resp_valid_i))
        else $error("line request while a read was outstanding");

endmodule

// ==== tb_clock_gen.sv ====
/* Testbench clock and power-on reset */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 5
) (
    output logic clk_o,
    output logic rstn_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk_o = ~clk_o;
        end
    end

    initial begin
        // Start high so the async reset flops see a falling reset edge
        rstn_o = 1'b1;
        #1;
        rstn_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        // Release a quarter period after the edge, clear of both clock edges
        #(PERIOD_NS / 4);
        rstn_o = 1'b1;
    end

endmodule

// ==== fetch_top.sv ====
/* Fetch front end top level, PC unit, icache interface, line store
   and instruction queue wired together */
`timescale 1ns/1ps

module fetch_top
    import fetch_pkg::*;
#(
    parameter addr_t       RESET_PC    = '0,
    parameter int unsigned MEM_LATENCY = 3,
    parameter int unsigned QUEUE_DEPTH = 4
) (
    input  logic      clk_i,
    input  logic      rstn_i,

    // Redirect from a later stage
    input  logic      redirect_valid_i,
    input  addr_t     redirect_pc_i,

    // Line store load port
    input  logic      mem_wr_en_i,
    input  line_idx_t mem_wr_idx_i,
    input  line_t     mem_wr_line_i,

    // Decode side
    output logic      instr_valid_o,
    output instr_t    instr_o,
    output addr_t     instr_pc_o,
    input  logic      instr_ready_i
);

    // PC unit to interface
    logic      fetch_valid;
    addr_t     fetch_pc;
    logic      buffer_flush;

    // Interface to queue
    logic      word_valid;
    instr_t    word;
    logic      queue_ready;
    logic      xfer;

    // Interface to line store
    logic      mem_req_valid;
    line_idx_t mem_req_idx;
    logic      mem_req_ready;
    logic      mem_resp_valid;
    line_t     mem_resp_line;
    line_idx_t mem_resp_idx;

    // PC steps only when the queue takes the word
    assign xfer = word_valid && queue_ready;

    fetch_pc_unit #(
        .RESET_PC (RESET_PC)
    ) u_pc_unit (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .redirect_valid_i (redirect_valid_i),
        .redirect_pc_i    (redirect_pc_i),
        .xfer_i           (xfer),
        .fetch_valid_o    (fetch_valid),
        .fetch_pc_o       (fetch_pc),
        .buffer_flush_o   (buffer_flush)
    );

    icache_interface u_icache_if (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .fetch_valid_i    (fetch_valid),
        .fetch_pc_i       (fetch_pc),
        .buffer_flush_i   (buffer_flush),
        .word_valid_o     (word_valid),
        .word_o           (word),
        .mem_req_valid_o  (mem_req_valid),
        .mem_req_idx_o    (mem_req_idx),
        .mem_req_ready_i  (mem_req_ready),
        .mem_resp_valid_i (mem_resp_valid),
        .mem_resp_line_i  (mem_resp_line),
        .mem_resp_idx_i   (mem_resp_idx)
    );

    icache_line_mem #(
        .MEM_LATENCY (MEM_LATENCY)
    ) u_line_mem (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .req_valid_i  (mem_req_valid),
        .req_idx_i    (mem_req_idx),
        .req_ready_o  (mem_req_ready),
        .resp_valid_o (mem_resp_valid),
        .resp_line_o  (mem_resp_line),
        .resp_idx_o   (mem_resp_idx),
        .wr_en_i      (mem_wr_en_i),
        .wr_idx_i     (mem_wr_idx_i),
        .wr_line_i    (mem_wr_line_i)
    );

    // Word and its fetch address enter the queue together
    fetch_instr_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_instr_queue (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .flush_i       (buffer_flush),
        .push_valid_i  (word_valid),
        .push_instr_i  (word),
        .push_pc_i     (fetch_pc),
        .push_ready_o  (queue_ready),
        .instr_valid_o (instr_valid_o),
        .instr_o       (instr_o),
        .instr_pc_o    (instr_pc_o),
        .instr_ready_i (instr_ready_i)
    );

endmodule

// ==== fetch_instr_queue.sv ====
/* Circular FIFO of instruction and address pairs toward decode */
`timescale 1ns/1ps

module fetch_instr_queue
    import fetch_pkg::*;
#(
    parameter int unsigned QUEUE_DEPTH = 4
) (
    input  logic   clk_i,
    input  logic   rstn_i,
    input  logic   flush_i,

    // Write side from the icache interface
    input  logic   push_valid_i,
    input  instr_t push_instr_i,
    input  addr_t  push_pc_i,
    output logic   push_ready_o,

    // Read side toward decode
    output logic   instr_valid_o,
    output instr_t instr_o,
    output addr_t  instr_pc_o,
    input  logic   instr_ready_i
);

    localparam int PTR_WIDTH = $clog2(QUEUE_DEPTH);

    instr_t instr_q [QUEUE_DEPTH];
    addr_t  pc_q    [QUEUE_DEPTH];

    logic [PTR_WIDTH-1:0] wr_ptr_q;
    logic [PTR_WIDTH-1:0] rd_ptr_q;
    // One extra bit to tell full from empty
    logic [PTR_WIDTH:0]   count_q;

    logic push;
    logic pop;

    assign push_ready_o = (count_q != (PTR_WIDTH+1)'(QUEUE_DEPTH));
    assign instr_valid_o = (count_q != '0);
    assign push = push_valid_i && push_ready_o;
    assign pop = instr_valid_o && instr_ready_i;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q <= '0;
        end else if (flush_i) begin
            // Drop everything fetched before the redirect
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + PTR_WIDTH'(1);
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + PTR_WIDTH'(1);
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + (PTR_WIDTH+1)'(1);
                2'b01:   count_q <= count_q - (PTR_WIDTH+1)'(1);
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            instr_q[wr_ptr_q] <= push_instr_i;
            pc_q[wr_ptr_q] <= push_pc_i;
        end
    end

    // Head entry, visible the cycle after its write
    assign instr_o = instr_q[rd_ptr_q];
    assign instr_pc_o = pc_q[rd_ptr_q];

endmodule

// ==== icache_line_mem.sv ====
/* Instruction line store with a write port and a fixed-latency read port
   that serves one outstanding request at a time */
`timescale 1ns/1ps

module icache_line_mem
    import fetch_pkg::*;
#(
    parameter int unsigned MEM_LATENCY = 3
) (
    input  logic      clk_i,
    input  logic      rstn_i,

    // Line read request
    input  logic      req_valid_i,
    input  line_idx_t req_idx_i,
    output logic      req_ready_o,

    // Line read response
    output logic      resp_valid_o,
    output line_t     resp_line_o,
    output line_idx_t resp_idx_o,

    // Load port, one line per cycle
    input  logic      wr_en_i,
    input  line_idx_t wr_idx_i,
    input  line_t     wr_line_i
);

    localparam int CNT_WIDTH = $clog2(MEM_LATENCY + 1);

    line_t mem_q [NUM_LINES];

    // Cycles left until the response, zero when idle
    logic [CNT_WIDTH-1:0] cnt_q;
    line_idx_t            req_idx_q;
    logic                 accept;

    // Ready again in the response cycle
    assign req_ready_o = (cnt_q <= CNT_WIDTH'(1));
    assign accept = req_valid_i && req_ready_o;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            cnt_q <= '0;
        end else if (accept) begin
            cnt_q <= CNT_WIDTH'(MEM_LATENCY);
        end else if (cnt_q != '0) begin
            cnt_q <= cnt_q - CNT_WIDTH'(1);
        end
    end

    // Index of the outstanding read
    always_ff @(posedge clk_i) begin
        if (accept) begin
            req_idx_q <= req_idx_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            mem_q[wr_idx_i] <= wr_line_i;
        end
    end

    // Response exactly MEM_LATENCY cycles after acceptance
    assign resp_valid_o = (cnt_q == CNT_WIDTH'(1));
    assign resp_idx_o = req_idx_q;

    // Array read at response time, earlier writes show up
    assign resp_line_o = mem_q[req_idx_q];

endmodule

// ==== icache_interface.sv ====
/* One-line instruction buffer with request FSM and replay,
   selects the 32-bit word for the current fetch address */
`timescale 1ns/1ps

module icache_interface
    import fetch_pkg::*;
(
    input  logic      clk_i,
    input  logic      rstn_i,

    // Fetch request from the PC unit
    input  logic      fetch_valid_i,
    input  addr_t     fetch_pc_i,
    input  logic      buffer_flush_i,

    // Instruction word toward the queue
    output logic      word_valid_o,
    output instr_t    word_o,

    // Line request toward the line store
    output logic      mem_req_valid_o,
    output line_idx_t mem_req_idx_o,
    input  logic      mem_req_ready_i,

    // Line response from the line store
    input  logic      mem_resp_valid_i,
    input  line_t     mem_resp_line_i,
    input  line_idx_t mem_resp_idx_i
);

    // Buffered line, its index and valid bit
    line_t     line_q;
    line_idx_t buf_idx_q;
    logic      valid_q;
    logic      valid_d;

    // Index of the fetch address in the previous cycle
    line_idx_t old_idx_q;

    line_idx_t                 pc_idx;
    logic [WORD_SEL_WIDTH-1:0] word_sel;
    line_t                     line_int;

    logic buffer_miss;
    logic access_needed;
    logic resp_match;
    logic need_req;
    logic issue;
    logic idx_changed;

    icache_state_t state_q;
    icache_state_t state_d;

    assign pc_idx = fetch_pc_i[ADDR_WIDTH-1:LINE_OFFSET];
    assign word_sel = fetch_pc_i[LINE_OFFSET-1:LINE_OFFSET-WORD_SEL_WIDTH];

    // Miss when nothing is buffered or the buffered line is another one
    assign buffer_miss = !valid_q || (buf_idx_q != pc_idx);
    assign access_needed = fetch_valid_i && buffer_miss;

    // Responses for an old index are dropped here
    assign resp_match = mem_resp_valid_i && (mem_resp_idx_i == pc_idx);

    // A matching response this cycle already fills the miss
    assign need_req = access_needed && !resp_match;

    // Only present a request the store can take
    assign issue = need_req && mem_req_ready_i;

    assign idx_changed = (old_idx_q != pc_idx);

    always_comb begin
        state_d = state_q;
        mem_req_valid_o = 1'b0;
        case (state_q)
            NoReq: begin
                // New miss, retry later if the store is busy
                mem_req_valid_o = issue;
                if (issue) begin
                    state_d = ReqValid;
                end else if (need_req) begin
                    state_d = Replay;
                end
            end
            ReqValid: begin
                if (idx_changed) begin
                    // PC left the requested line, go after the new one
                    mem_req_valid_o = issue;
                    if (issue) begin
                        state_d = ReqValid;
                    end else if (need_req) begin
                        state_d = Replay;
                    end else begin
                        state_d = NoReq;
                    end
                end else if (resp_match || !access_needed) begin
                    // Line arrived or is no longer wanted
                    state_d = NoReq;
                end
            end
            Replay: begin
                // Store was busy, re-issue as soon as it frees up
                mem_req_valid_o = issue;
                if (issue) begin
                    state_d = ReqValid;
                end else if (!need_req) begin
                    state_d = NoReq;
                end
            end
            default: begin
                state_d = NoReq;
            end
        endcase
    end

    assign mem_req_idx_o = pc_idx;

    // Flush clears the buffer even when a line lands the same cycle
    assign valid_d = (valid_q || resp_match) && !buffer_flush_i;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q <= NoReq;
            valid_q <= 1'b0;
            old_idx_q <= '0;
        end else begin
            state_q <= state_d;
            valid_q <= valid_d;
            old_idx_q <= pc_idx;
        end
    end

    // Capture the matching line and its index
    always_ff @(posedge clk_i) begin
        if (resp_match) begin
            line_q <= mem_resp_line_i;
            buf_idx_q <= pc_idx;
        end
    end

    // Forward the response in the cycle it arrives
    assign line_int = resp_match ? mem_resp_line_i : line_q;

    assign word_valid_o = fetch_valid_i && (!buffer_miss || resp_match);

    // PC bits 3:2 pick one of the four words
    assign word_o = line_int[word_sel*INSTR_WIDTH +: INSTR_WIDTH];

endmodule

// ==== fetch_pc_unit.sv ====
/* Program counter with sequential advance and redirect handling */
`timescale 1ns/1ps

module fetch_pc_unit
    import fetch_pkg::*;
#(
    parameter addr_t RESET_PC = '0
) (
    input  logic  clk_i,
    input  logic  rstn_i,

    // Redirect from a later stage
    input  logic  redirect_valid_i,
    input  addr_t redirect_pc_i,

    // Word moved from the interface into the queue
    input  logic  xfer_i,

    // Fetch request toward the icache interface
    output logic  fetch_valid_o,
    output addr_t fetch_pc_o,
    output logic  buffer_flush_o
);

    // One instruction is 4 bytes, no compressed support
    localparam addr_t PC_STEP = addr_t'(INSTR_WIDTH / 8);

    addr_t pc_q;
    addr_t pc_d;
    logic  fetch_valid_q;

    // Redirect wins over the sequential step
    always_comb begin
        pc_d = pc_q;
        if (redirect_valid_i) begin
            pc_d = redirect_pc_i;
        end else if (xfer_i) begin
            pc_d = pc_q + PC_STEP;
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            pc_q <= RESET_PC;
            fetch_valid_q <= 1'b0;
        end else begin
            pc_q <= pc_d;
            // Fetch starts the cycle after reset and never stops
            fetch_valid_q <= 1'b1;
        end
    end

    assign fetch_valid_o = fetch_valid_q;
    assign fetch_pc_o = pc_q;

    // Old line and queued words are stale once the PC jumps
    assign buffer_flush_o = redirect_valid_i;

endmodule

// ==== fetch_pkg.sv ====
/* Shared widths, line geometry and types of the instruction fetch front end,
   plus the state encoding of the icache interface FSM */
package fetch_pkg;

    // 4 KiB of byte addressed instruction space
    localparam int ADDR_WIDTH = 12;
    localparam int INSTR_WIDTH = 32;

    // Four instruction words per 16-byte line
    localparam int WORDS_PER_LINE = 4;
    localparam int LINE_WIDTH = INSTR_WIDTH * WORDS_PER_LINE;
    localparam int LINE_OFFSET = 4;
    localparam int WORD_SEL_WIDTH = 2;

    // Line index is the byte address without its offset bits
    localparam int LINE_IDX_WIDTH = ADDR_WIDTH - LINE_OFFSET;
    localparam int NUM_LINES = 1 << LINE_IDX_WIDTH;

    typedef logic [ADDR_WIDTH-1:0]     addr_t;
    typedef logic [INSTR_WIDTH-1:0]    instr_t;
    // Word 0 lives in the low bits of the line
    typedef logic [LINE_WIDTH-1:0]     line_t;
    typedef logic [LINE_IDX_WIDTH-1:0] line_idx_t;

    // Request FSM of the icache interface
    typedef enum logic [1:0] {
        NoReq,
        ReqValid,
        Replay
    } icache_state_t;

endpackage
